// ==== Bender.yml ====
package:
  name: load_unit

sources:
  - mem_pkg.sv
  - load_decode.sv
  - dcache_data_array.sv
  - mem_rd_data_gen.sv
  - load_format.sv
  - load_unit_top.sv
  - target: test
    files:
      - load_checker.sv
      - tb_load_unit.sv

// ==== dcache_data_array.sv ====
`timescale 1ns/1ns

module dcache_data_array #(
  parameter int NUM_SETS = 64
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         rd_en,
  input  logic [27:0]  rd_line_addr,
  input  logic         fill_we,
  input  logic [27:0]  fill_addr,
  input  logic [127:0] fill_line,
  output logic [127:0] dc_rd_data,
  output logic         dc_read_hit
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = 28 - IDX_W;

  // One set of the array
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [127:0]     data;
  } entry_t;

  entry_t              entries [NUM_SETS];
  logic [NUM_SETS-1:0] valid;
  logic [IDX_W-1:0]    rd_idx;
  logic [TAG_W-1:0]    rd_tag;
  logic [IDX_W-1:0]    fill_idx;
  logic [TAG_W-1:0]    fill_tag;
  entry_t              rd_entry;

  // Low line address bits pick the set
  assign rd_idx   = rd_line_addr[IDX_W-1:0];
  assign rd_tag   = rd_line_addr[27:IDX_W];
  assign fill_idx = fill_addr[IDX_W-1:0];
  assign fill_tag = fill_addr[27:IDX_W];

  assign rd_entry = entries[rd_idx];

  // Valid bits
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0; // Empty cache
    end else if (fill_we) begin
      valid[fill_idx] <= 1'b1;
    end
  end

  // Line and tag storage
  always_ff @(posedge clk) begin
    if (fill_we) begin
      entries[fill_idx].tag  <= fill_tag;
      entries[fill_idx].data <= fill_line; // Whole line in one write
    end
  end

  // Registered read data
  always_ff @(posedge clk) begin
    if (rd_en) begin
      dc_rd_data <= rd_entry.data; // Held until the next read
    end
  end

  // Tag compare, registered with the data
  always_ff @(posedge clk) begin
    if (reset) begin
      dc_read_hit <= 1'b0;
    end else if (rd_en) begin
      dc_read_hit <= valid[rd_idx] && (rd_entry.tag == rd_tag);
    end
  end

endmodule

// ==== list.f ====
mem_pkg.sv
load_decode.sv
dcache_data_array.sv
mem_rd_data_gen.sv
load_format.sv
load_unit_top.sv
load_checker.sv
tb_load_unit.sv

// ==== load_checker.sv ====
`timescale 1ns/1ns

module load_checker #(
  parameter logic [31:0] IO_BASE = 32'hFFFF_0000
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  mem_pkg::load_op_e     req_op,
  input  logic [31:0]           req_addr,
  input  logic                  busy,
  input  logic                  fill_we,
  input  logic [27:0]           fill_addr,
  input  logic [127:0]          fill_line,
  input  logic                  io_req,
  input  logic [31:0]           io_addr,
  input  logic                  io_ack,
  input  logic [31:0]           io_rd_data,
  input  logic                  done,
  input  mem_pkg::load_result_t result,
  input  logic                  report,
  output int                    error_count
);

  logic [27:0]       mirror_addr [16]; // Lines written through the fill port
  logic [127:0]      mirror_data [16];
  int                mirror_count = 0;
  logic              pending = 1'b0;   // Accepted load without done yet
  mem_pkg::load_op_e p_op;
  logic [31:0]       p_addr;
  int                p_cycle = 0;
  logic [31:0]       io_data = '0;     // Last word on the IO return
  int                io_cycle = 0;
  int                cycle_no = 0;
  int                accepted = 0;
  int                dones = 0;
  int                ignored = 0;
  logic              io_req_exp;       // IO strobe due this cycle

  initial error_count = 0;

  function automatic int size_of(input mem_pkg::load_op_e op);
    case (op)
      mem_pkg::LD_B, mem_pkg::LD_BU: return 1;
      mem_pkg::LD_H, mem_pkg::LD_HU: return 2;
      mem_pkg::LD_W, mem_pkg::LD_WU: return 4;
      default:                       return 8;
    endcase
  endfunction

  function automatic logic find_line(input logic [27:0] la, output logic [127:0] line);
    logic hit;
    int   j;
    hit  = 1'b0;
    line = '0;
    for (j = 0; j < mirror_count; j++) begin
      if (mirror_addr[j] == la) begin
        hit  = 1'b1;
        line = mirror_data[j]; // Latest fill wins
      end
    end
    return hit;
  endfunction

  // Little-endian byte gather, then size and extend
  function automatic mem_pkg::load_result_t expected_result(
    input mem_pkg::load_op_e op,
    input logic [31:0]       addr,
    input logic [31:0]       io_word
  );
    mem_pkg::load_result_t r;
    logic [63:0]           raw;
    logic [127:0]          line;
    logic [31:0]           byte_addr;
    logic                  sign;
    int                    n;
    int                    i;
    raw    = '0;
    r.miss = 1'b0;
    n      = size_of(op);
    if (addr >= IO_BASE) begin
      raw[31:0] = io_word; // IO port is 32 bits
    end else begin
      for (i = 0; i < n; i++) begin
        byte_addr = addr + i;
        if (find_line(byte_addr[31:4], line)) begin
          raw[i*8 +: 8] = line[byte_addr[3:0]*8 +: 8];
        end else begin
          r.miss = 1'b1; // Any byte from an unfilled line
        end
      end
    end
    sign = (op == mem_pkg::LD_B || op == mem_pkg::LD_H || op == mem_pkg::LD_W) && raw[n*8-1];
    for (i = n * 8; i < 64; i++) begin
      raw[i] = sign;
    end
    r.data = r.miss ? 64'h0 : raw;
    return r;
  endfunction

  task automatic check_done();
    mem_pkg::load_result_t exp;
    int                    lat_exp;
    int                    errs;
    dones++;
    if (!pending) begin
      $display("Done pulse at %0t with no accepted load in flight", $time);
      error_count++;
      return;
    end
    errs = 0;
    exp  = expected_result(p_op, p_addr, io_data);
    if (p_addr >= IO_BASE) begin
      lat_exp = io_cycle + 1 - p_cycle; // Cycle after io_ack
    end else if (p_addr[3:0] + size_of(p_op) > 16) begin
      lat_exp = 4; // Two line reads
    end else begin
      lat_exp = 3;
    end
    if (result.data !== exp.data) begin
      $display("CHECK FAILED at %0t: result.data expected %h got %h", $time, exp.data, result.data);
      errs++;
    end
    if (result.miss !== exp.miss) begin
      $display("CHECK FAILED at %0t: result.miss expected %b got %b", $time, exp.miss, result.miss);
      errs++;
    end
    if (cycle_no - p_cycle != lat_exp) begin
      $display("CHECK FAILED at %0t: done latency expected %0d got %0d", $time, lat_exp,
               cycle_no - p_cycle);
      errs++;
    end
    error_count += errs;
    $display("Load %0d %s at %h: %s", dones, p_op.name(), p_addr, (errs == 0) ? "ok" : "mismatch");
    pending = 1'b0;
  endtask

  task automatic final_report();
    if (pending) begin
      $display("Load at %h never signalled done", p_addr);
      error_count++;
    end
    if (dones != accepted) begin
      $display("Done pulse count %0d does not match %0d accepted requests", dones, accepted);
      error_count++;
    end
    $display("Summary: %0d loads accepted, %0d done pulses, %0d requests ignored, %0d errors",
             accepted, dones, ignored, error_count);
  endtask

  // Sample mid-cycle, away from the driving edge
  always @(negedge clk) begin
    cycle_no++;
    if (!reset) begin
      if (fill_we && mirror_count < 16) begin
        mirror_addr[mirror_count] = fill_addr;
        mirror_data[mirror_count] = fill_line;
        mirror_count++;
      end
      if (io_ack) begin
        io_data  = io_rd_data;
        io_cycle = cycle_no;
      end
      if (done) begin
        check_done();
      end
      if (busy !== (pending && cycle_no > p_cycle)) begin // High after accept until done
        $display("CHECK FAILED at %0t: busy expected %b got %b", $time,
                 pending && cycle_no > p_cycle, busy);
        error_count++;
      end
      io_req_exp = pending && (p_addr >= IO_BASE) && (cycle_no == p_cycle + 1);
      if (io_req !== io_req_exp) begin // One strobe, first cycle of an IO load
        $display("CHECK FAILED at %0t: io_req expected %b got %b", $time, io_req_exp, io_req);
        error_count++;
      end
      if (io_req && io_addr !== p_addr) begin
        $display("CHECK FAILED at %0t: io_addr expected %h got %h", $time, p_addr, io_addr);
        error_count++;
      end
      if (req && pending) begin
        ignored++;
      end else if (req) begin
        pending  = 1'b1;
        p_op     = req_op;
        p_addr   = req_addr;
        p_cycle  = cycle_no;
        io_cycle = 0; // Wait for a fresh ack
        accepted++;
      end
      if (report) begin
        final_report();
      end
    end
  end

endmodule

// ==== load_decode.sv ====
`timescale 1ns/1ns

module load_decode #(
  parameter logic [31:0] IO_BASE = 32'hFFFF_0000
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               req,
  input  mem_pkg::load_op_e  req_op,
  input  logic [31:0]        req_addr,
  input  logic               io_ack,
  output logic               busy,
  output logic               rd_en,
  output logic [27:0]        rd_line_addr,
  output mem_pkg::access_t   acc,
  output logic               access2,     // Second line data on the read bus
  output logic               io_req,
  output logic [31:0]        io_addr,
  output logic               take         // Final data valid at mem_rd_data
);

  mem_pkg::acc_state_e state;
  logic                accept;
  logic                req_io;
  logic [4:0]          end_byte;
  logic                rd_valid;            // Line data arrives this cycle
  logic                rd2_en;              // Second line read issued

  assign accept   = req && !busy; // Requests during busy are dropped
  assign req_io   = req_addr >= IO_BASE;
  assign end_byte = {1'b0, req_addr[3:0]} + {1'b0, mem_pkg::op_bytes(req_op)};

  assign busy   = state != mem_pkg::ST_IDLE;
  assign rd2_en = (state == mem_pkg::ST_LINE2) && !access2;
  assign rd_en  = ((state == mem_pkg::ST_LINE1) && !rd_valid) || rd2_en;

  // Next line for the spill part
  assign rd_line_addr = rd2_en ? acc.line_addr + 28'd1 : acc.line_addr;

  assign take = ((state == mem_pkg::ST_LINE1) && rd_valid) || // Single line
                ((state == mem_pkg::ST_LINE2) && access2) ||  // Merged lines
                ((state == mem_pkg::ST_IO) && io_ack);        // IO return

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= mem_pkg::ST_IDLE;
      rd_valid <= 1'b0;
      access2  <= 1'b0;
      io_req   <= 1'b0;
    end else begin
      rd_valid <= rd_en;            // Read data is one cycle behind rd_en
      access2  <= rd2_en;
      io_req   <= accept && req_io; // One-cycle IO strobe
      case (state)
        mem_pkg::ST_IDLE: begin
          if (accept) begin
            state <= req_io ? mem_pkg::ST_IO : mem_pkg::ST_LINE1;
          end
        end
        mem_pkg::ST_LINE1: begin
          if (acc.crosses) begin
            state <= mem_pkg::ST_LINE2; // Overlap line 2 read with line 1 data
          end else if (rd_valid) begin
            state <= mem_pkg::ST_IDLE;
          end
        end
        mem_pkg::ST_LINE2: begin
          if (access2) begin
            state <= mem_pkg::ST_IDLE;
          end
        end
        mem_pkg::ST_IO: begin
          if (io_ack) begin
            state <= mem_pkg::ST_IDLE; // Latency set by the IO side
          end
        end
        default: state <= mem_pkg::ST_IDLE;
      endcase
    end
  end

  // Request capture
  always_ff @(posedge clk) begin
    if (accept) begin
      acc.op          <= req_op;
      acc.line_addr   <= req_addr[31:4];
      acc.addr_offset <= req_addr[3:0];
      acc.crosses     <= !req_io && (end_byte > mem_pkg::LINE_BYTES);
      acc.is_io       <= req_io;
      io_addr         <= req_addr;
    end
  end

endmodule

// ==== load_format.sv ====
`timescale 1ns/1ns

module load_format (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  take,
  input  mem_pkg::load_op_e     op,
  input  logic [63:0]           mem_rd_data,
  input  logic                  rd_miss,
  output logic                  done,
  output mem_pkg::load_result_t result
);

  logic [63:0] fmt_data;

  // Trim to size and extend
  always_comb begin
    case (op)
      mem_pkg::LD_B:  fmt_data = {{56{mem_rd_data[7]}}, mem_rd_data[7:0]};
      mem_pkg::LD_BU: fmt_data = {56'h0, mem_rd_data[7:0]};
      mem_pkg::LD_H:  fmt_data = {{48{mem_rd_data[15]}}, mem_rd_data[15:0]};
      mem_pkg::LD_HU: fmt_data = {48'h0, mem_rd_data[15:0]};
      mem_pkg::LD_W:  fmt_data = {{32{mem_rd_data[31]}}, mem_rd_data[31:0]};
      mem_pkg::LD_WU: fmt_data = {32'h0, mem_rd_data[31:0]};
      default:        fmt_data = mem_rd_data; // LD_D
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= take; // One pulse per load
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      result.data <= rd_miss ? 64'h0 : fmt_data; // Missed loads return zero
      result.miss <= rd_miss;
    end
  end

endmodule

// ==== load_unit_top.sv ====
`timescale 1ns/1ns

module load_unit_top #(
  parameter logic [31:0] IO_BASE  = 32'hFFFF_0000,
  parameter int          NUM_SETS = 64
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  mem_pkg::load_op_e     req_op,
  input  logic [31:0]           req_addr,
  output logic                  busy,
  input  logic                  fill_we,
  input  logic [27:0]           fill_addr,
  input  logic [127:0]          fill_line,
  output logic                  io_req,
  output logic [31:0]           io_addr,
  input  logic                  io_ack,
  input  logic [31:0]           io_rd_data,
  output logic                  done,
  output mem_pkg::load_result_t result
);

  logic             rd_en;
  logic [27:0]      rd_line_addr;
  mem_pkg::access_t acc;
  logic             access2;
  logic             take;
  logic [127:0]     dc_rd_data;
  logic             dc_read_hit;
  logic [63:0]      mem_rd_data;
  logic             rd_miss;

  load_decode #(.IO_BASE(IO_BASE)) u_load_decode (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .req_op       (req_op),
    .req_addr     (req_addr),
    .io_ack       (io_ack),
    .busy         (busy),
    .rd_en        (rd_en),
    .rd_line_addr (rd_line_addr),
    .acc          (acc),
    .access2      (access2),
    .io_req       (io_req),
    .io_addr      (io_addr),
    .take         (take)
  );

  dcache_data_array #(.NUM_SETS(NUM_SETS)) u_dcache_data_array (
    .clk          (clk),
    .reset        (reset),
    .rd_en        (rd_en),
    .rd_line_addr (rd_line_addr),
    .fill_we      (fill_we),
    .fill_addr    (fill_addr),
    .fill_line    (fill_line),
    .dc_rd_data   (dc_rd_data),
    .dc_read_hit  (dc_read_hit)
  );

  mem_rd_data_gen u_mem_rd_data_gen (
    .clk         (clk),
    .reset       (reset),
    .dc_rd_data  (dc_rd_data),
    .addr_offset (acc.addr_offset),
    .access2_reg (access2),      // Already one cycle after the line 2 read
    .dc_read_hit (dc_read_hit),
    .io_rd_data  (io_rd_data),
    .io_ack      (io_ack),
    .mem_rd_data (mem_rd_data),
    .rd_miss     (rd_miss)
  );

  load_format u_load_format (
    .clk         (clk),
    .reset       (reset),
    .take        (take),
    .op          (acc.op),
    .mem_rd_data (mem_rd_data),
    .rd_miss     (rd_miss),
    .done        (done),
    .result      (result)
  );

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

  localparam int LINE_BYTES = 16; // Bytes per cache line

  // Load opcodes, size and signedness
  typedef enum logic [2:0] {
    LD_B  = 3'd0, // Byte, sign extended
    LD_BU = 3'd1, // Byte, zero extended
    LD_H  = 3'd2, // Half, sign extended
    LD_HU = 3'd3, // Half, zero extended
    LD_W  = 3'd4, // Word, sign extended
    LD_WU = 3'd5, // Word, zero extended
    LD_D  = 3'd6  // Double, full width
  } load_op_e;

  // Access sequencer states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0, // Waiting for a request
    ST_LINE1 = 2'd1, // First (or only) line read
    ST_LINE2 = 2'd2, // Second line of a crossing load
    ST_IO    = 2'd3  // Waiting on the IO port
  } acc_state_e;

  // Decoded load access
  typedef struct packed {
    load_op_e    op;          // Load opcode
    logic [27:0] line_addr;   // Address of the first line
    logic [3:0]  addr_offset; // Byte offset in the line
    logic        crosses;     // Load spills into the next line
    logic        is_io;       // Address falls in the IO window
  } access_t;

  // Formatted load value
  typedef struct packed {
    logic [63:0] data; // Sized and extended value
    logic        miss; // Some line read missed
  } load_result_t;

  // Access size in bytes
  function automatic logic [3:0] op_bytes(load_op_e op);
    logic [3:0] n;
    case (op)
      LD_B, LD_BU: n = 4'd1;
      LD_H, LD_HU: n = 4'd2;
      LD_W, LD_WU: n = 4'd4;
      default:     n = 4'd8; // LD_D
    endcase
    return n;
  endfunction

endpackage

// ==== mem_rd_data_gen.sv ====
`timescale 1ns/1ns

module mem_rd_data_gen (
  input  logic         clk,
  input  logic         reset,
  input  logic [127:0] dc_rd_data,
  input  logic [3:0]   addr_offset,
  input  logic         access2_reg,
  input  logic         dc_read_hit,
  input  logic [31:0]  io_rd_data,
  input  logic         io_ack,
  output logic [63:0]  mem_rd_data,
  output logic         rd_miss
);

  logic [127:0] rot_line; // Addressed byte in lane 0
  logic [63:0]  mdr;      // Low bytes of the first line
  logic         mdr_miss; // First line missed
  logic         ld_mdr;
  logic [7:0]   sel_mask; // Lanes taken from the current line
  logic [63:0]  merged;

  // Byte rotate by the offset, wrapping inside the line
  always_comb begin
    logic [3:0] src;
    src = 4'd0;
    for (int i = 0; i < mem_pkg::LINE_BYTES; i++) begin
      src = 4'(i) + addr_offset;
      rot_line[i*8 +: 8] = dc_rd_data[src*8 +: 8];
    end
  end

  // Lane i belongs to line 2 once i + offset passes the line end
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      if (access2_reg) begin
        sel_mask[i] = (i + addr_offset) >= mem_pkg::LINE_BYTES;
      end else begin
        sel_mask[i] = 1'b1; // Single line, no merge
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      merged[i*8 +: 8] = sel_mask[i] ? rot_line[i*8 +: 8] : mdr[i*8 +: 8];
    end
  end

  assign ld_mdr = dc_read_hit && !access2_reg; // First line hit

  always_ff @(posedge clk) begin
    if (reset) begin
      mdr      <= '0;
      mdr_miss <= 1'b0;
    end else begin
      if (ld_mdr) begin
        mdr <= rot_line[63:0];
      end
      if (!access2_reg) begin
        mdr_miss <= !dc_read_hit; // Kept for the second line cycle
      end
    end
  end

  // Miss on either line of the access, IO never misses
  assign rd_miss = !io_ack && (!dc_read_hit || (access2_reg && mdr_miss));

  // IO data replaces the cache path
  assign mem_rd_data = io_ack ? {32'h0000_0000, io_rd_data} : merged;

endmodule

// ==== tb_load_unit.sv ====
`timescale 1ns/1ns

module tb_load_unit;

  localparam logic [31:0] IO_BASE        = 32'hFFFF_0000;
  localparam int          NUM_SETS       = 64;
  localparam int          NUM_LOADS      = 70; // 35 in-line, 15 crossing, 14 IO, 4 miss, 2 busy
  localparam int          PRELOAD_CYCLES = 30; // Reset, 16 fills and slack
  localparam int          CYCLE_LIMIT    = 40 * NUM_LOADS + PRELOAD_CYCLES;
  localparam int          DONE_WAIT      = 40; // Cycles allowed per load

  logic                  clk;
  logic                  reset;
  logic                  req;
  mem_pkg::load_op_e     req_op;
  logic [31:0]           req_addr;
  logic                  busy;
  logic                  fill_we;
  logic [27:0]           fill_addr;
  logic [127:0]          fill_line;
  logic                  io_req;
  logic [31:0]           io_addr;
  logic                  io_ack;
  logic [31:0]           io_rd_data;
  logic                  done;
  mem_pkg::load_result_t result;
  logic                  report;      // Asks the checker for its summary
  int                    error_count;
  int                    late_count = 0;
  int                    cycle_count = 0;
  integer                seed = 32'hb9157953;

  load_unit_top #(.IO_BASE(IO_BASE), .NUM_SETS(NUM_SETS)) UUT (
    .clk(clk), .reset(reset), .req(req), .req_op(req_op), .req_addr(req_addr),
    .busy(busy), .fill_we(fill_we), .fill_addr(fill_addr), .fill_line(fill_line),
    .io_req(io_req), .io_addr(io_addr), .io_ack(io_ack), .io_rd_data(io_rd_data),
    .done(done), .result(result)
  );

  load_checker #(.IO_BASE(IO_BASE)) u_load_checker (
    .clk(clk), .reset(reset), .req(req), .req_op(req_op), .req_addr(req_addr),
    .busy(busy), .fill_we(fill_we), .fill_addr(fill_addr), .fill_line(fill_line),
    .io_req(io_req), .io_addr(io_addr),
    .io_ack(io_ack), .io_rd_data(io_rd_data), .done(done), .result(result),
    .report(report), .error_count(error_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run stopped at the cycle limit of %0d with loads still open", CYCLE_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // IO side answers 1 to 4 cycles after io_req
  initial begin : io_responder
    int delay;
    io_ack     = 1'b0;
    io_rd_data = '0;
    forever begin
      @(posedge clk);
      if (io_req) begin
        delay = 1 + ({$random(seed)} % 4);
        repeat (delay - 1) @(posedge clk);
        io_ack     <= 1'b1;
        io_rd_data <= $random(seed);
        @(posedge clk);
        io_ack <= 1'b0;
      end
    end
  end

  task automatic issue_req(input mem_pkg::load_op_e op, input logic [31:0] addr);
    @(posedge clk);
    req      <= 1'b1;
    req_op   <= op;
    req_addr <= addr;
    @(posedge clk);
    req <= 1'b0; // One-cycle strobe
  endtask

  task automatic wait_done(input logic [31:0] addr);
    int n;
    n = 0;
    @(posedge clk);
    while (done !== 1'b1 && n < DONE_WAIT) begin
      @(posedge clk);
      n++;
    end
    if (done !== 1'b1) begin
      $display("No done pulse within %0d cycles for the load at %h", DONE_WAIT, addr);
      late_count++;
    end
  endtask

  task automatic run_load(input mem_pkg::load_op_e op, input logic [31:0] addr);
    issue_req(op, addr);
    wait_done(addr);
  endtask

  initial begin : stimulus
    logic [127:0] line_val;
    logic [31:0]  addr;
    int           i;
    int           w;
    int           k;
    int           op_i;
    int           off;
    req       = 1'b0;
    req_op    = mem_pkg::LD_B;
    req_addr  = '0;
    fill_we   = 1'b0;
    fill_addr = '0;
    fill_line = '0;
    report    = 1'b0;
    reset     = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    for (i = 0; i < 16; i++) begin // Lines 0x400 to 0x40F, sets 0 to 15
      for (w = 0; w < 4; w++) begin
        line_val[w*32 +: 32] = $random(seed);
      end
      @(posedge clk);
      fill_we   <= 1'b1;
      fill_addr <= 28'h000_0400 + 28'(i);
      fill_line <= line_val;
    end
    @(posedge clk);
    fill_we <= 1'b0;
    for (op_i = 0; op_i < 7; op_i++) begin // Offsets 0, 3, 4, 7, 8 stay in the line
      for (k = 0; k < 5; k++) begin
        addr = 32'h0000_4000 + 32'(((op_i * 5 + k) % 16) * 16) + 32'(k * 2 + k % 2);
        run_load(mem_pkg::load_op_e'(op_i), addr);
      end
    end
    for (off = 9; off < 16; off++) begin // Only sizes that spill over
      for (op_i = 2; op_i < 7; op_i++) begin
        if (off + (1 << (op_i / 2)) > 16) begin
          run_load(mem_pkg::load_op_e'(op_i), 32'h0000_4000 + 32'((off - 9) * 16 + off));
        end
      end
    end
    for (op_i = 0; op_i < 7; op_i++) begin
      run_load(mem_pkg::load_op_e'(op_i), IO_BASE + 32'(op_i * 8));
      run_load(mem_pkg::load_op_e'(op_i), IO_BASE + 32'h1234 + 32'(op_i));
    end
    run_load(mem_pkg::LD_W, 32'h0000_4204);  // Set 32 never filled
    run_load(mem_pkg::LD_D, 32'h0000_8000);  // Set 0, other tag
    run_load(mem_pkg::LD_D, 32'h0000_40FC);  // Second line unfilled
    run_load(mem_pkg::LD_HU, 32'h0000_3FFF); // First line unfilled
    issue_req(mem_pkg::LD_W, 32'h0000_4024);
    issue_req(mem_pkg::LD_D, 32'h0000_4050); // Lands while busy
    wait_done(32'h0000_4024);
    issue_req(mem_pkg::LD_H, IO_BASE + 32'h0102);
    issue_req(mem_pkg::LD_B, IO_BASE + 32'h0004); // Lands during IO wait
    wait_done(IO_BASE + 32'h0102);
    repeat (6) @(posedge clk); // Room for a stray done
    report <= 1'b1;
    @(posedge clk);
    report <= 1'b0;
    @(posedge clk);
    if (error_count == 0 && late_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
